//--- fetch_pkg.sv
// fetch memory and bus constants
package fetch_pkg;

	// bus widths
	localparam int addr_width = 32;
	localparam int data_width = 32;

	// first address fetched after reset
	localparam logic [addr_width-1:0] reset_pc = 32'h8000_0000;

	// instruction memory geometry
	localparam int mem_words       = 256;
	localparam int mem_index_width = 8;

	// word index sits above the byte offset
	localparam int index_lsb = 2;
	localparam int upper_lsb = index_lsb + mem_index_width;

	// clock edges from address acceptance to rvalid
	localparam int read_latency   = 2;
	localparam int read_cnt_width = $clog2(read_latency + 1);

	// AXI-lite read response codes
	localparam logic [1:0] resp_okay   = 2'd0;
	localparam logic [1:0] resp_slverr = 2'd2;

endpackage

//--- rv_pkg.sv
// risc-v instruction encoding constants
package rv_pkg;

	// major opcode field in bits [6:0]
	localparam int opcode_width = 7;

	// jump and link
	localparam logic [opcode_width-1:0] opcode_jal = 7'b1101111;

	// J-type immediate is 21 bits including the implied zero lsb
	localparam int jimm_width = 21;

	// sequential step, no compressed instructions
	localparam int pc_step = 4;

endpackage

//--- ifu.sv
// instruction fetch unit
`timescale 1ns/1ps

module ifu (
	input  logic                              clk,
	input  logic                              rst,

	// read address channel
	output logic [fetch_pkg::addr_width-1:0]  araddr,
	output logic                              arvalid,
	input  logic                              arready,

	// read data channel
	input  logic [fetch_pkg::data_width-1:0]  rdata,
	input  logic [1:0]                        rresp,
	input  logic                              rvalid,
	output logic                              rready,

	// fetch output to the consumer
	output logic [fetch_pkg::addr_width-1:0]  out_pc,
	output logic [fetch_pkg::data_width-1:0]  out_inst,
	output logic                              out_fault,
	output logic                              out_valid,
	input  logic                              out_ready,

	// loop to the next-pc unit
	output logic [fetch_pkg::addr_width-1:0]  cur_pc,
	output logic [fetch_pkg::data_width-1:0]  cur_inst,
	output logic                              cur_fault,
	input  logic [fetch_pkg::addr_width-1:0]  next_pc
);
	import fetch_pkg::*;

	// one fetch in flight at a time
	typedef enum logic [1:0] {
		st_idle,
		st_addr,
		st_data,
		st_hold
	} state_t;

	state_t                state;
	state_t                state_next;
	logic [addr_width-1:0] pc;
	logic [data_width-1:0] inst_q;
	logic                  fault_q;
	logic                  ar_done;
	logic                  r_done;
	logic                  out_done;

	// handshake completions
	assign ar_done  = arvalid && arready;
	assign r_done   = rvalid && rready;
	assign out_done = out_valid && out_ready;

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= st_idle;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			st_idle: begin
				state_next = st_addr;
			end
			st_addr: begin
				if (ar_done) begin
					state_next = st_data;
				end
			end
			st_data: begin
				if (r_done) begin
					state_next = st_hold;
				end
			end
			st_hold: begin
				// stay here while the consumer stalls
				if (out_done) begin
					state_next = st_idle;
				end
			end
			default: begin
				state_next = st_idle;
			end
		endcase
	end

	// pc only moves once the current word has been taken
	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= reset_pc;
		end else if (out_done) begin
			pc <= next_pc;
		end
	end

	// hold register for the fetched word
	always_ff @(posedge clk) begin
		if (r_done) begin
			inst_q  <= rdata;
			fault_q <= (rresp != resp_okay);
		end
	end

	// channel controls follow the state directly
	assign araddr  = pc;
	assign arvalid = (state == st_addr);
	assign rready  = (state == st_data);

	assign out_valid = (state == st_hold);
	assign out_pc    = pc;
	assign out_inst  = inst_q;
	assign out_fault = fault_q;

	assign cur_pc    = pc;
	assign cur_inst  = inst_q;
	assign cur_fault = fault_q;

endmodule

//--- isram.sv
// instruction sram with AXI-lite read slave
`timescale 1ns/1ps

module isram (
	input  logic                                   clk,
	input  logic                                   rst,

	input  logic [fetch_pkg::addr_width-1:0]       araddr,
	input  logic                                   arvalid,
	output logic                                   arready,

	output logic [fetch_pkg::data_width-1:0]       rdata,
	output logic [1:0]                             rresp,
	output logic                                   rvalid,
	input  logic                                   rready,

	// preload port, one word per cycle
	input  logic                                   load_en,
	input  logic [fetch_pkg::mem_index_width-1:0]  load_index,
	input  logic [fetch_pkg::data_width-1:0]       load_data
);
	import fetch_pkg::*;

	logic [data_width-1:0]      mem [mem_words];
	logic                       pending;
	logic [read_cnt_width-1:0]  cnt;
	logic [mem_index_width-1:0] idx_q;
	logic                       hit_q;
	logic [mem_index_width-1:0] ar_index;
	logic                       in_range;
	logic                       ar_done;
	logic                       data_ready;

	// word index and region check on the incoming address
	assign ar_index = araddr[upper_lsb-1:index_lsb];
	assign in_range = (araddr[addr_width-1:upper_lsb] == reset_pc[addr_width-1:upper_lsb])
		&& (int'(ar_index) < mem_words);

	assign arready    = !pending;
	assign ar_done    = arvalid && arready;
	assign data_ready = pending && !rvalid && (cnt == read_cnt_width'(1));

	always_ff @(posedge clk) begin
		if (load_en) begin
			mem[load_index] <= load_data;
		end
	end

	// read sequencing
	always_ff @(posedge clk) begin
		if (rst) begin
			pending <= 1'b0;
			rvalid  <= 1'b0;
			cnt     <= '0;
		end else if (ar_done) begin
			pending <= 1'b1;
			cnt     <= read_cnt_width'(read_latency);
		end else if (data_ready) begin
			rvalid <= 1'b1;
		end else if (pending && !rvalid) begin
			cnt <= cnt - 1'b1;
		end else if (rvalid && rready) begin
			rvalid  <= 1'b0;
			pending <= 1'b0;
		end
	end

	// captured address, then the response word
	always_ff @(posedge clk) begin
		if (ar_done) begin
			idx_q <= ar_index;
			hit_q <= in_range;
		end
		if (data_ready) begin
			rdata <= hit_q ? mem[idx_q] : '0;
			rresp <= hit_q ? resp_okay : resp_slverr;
		end
	end

endmodule

//--- next_pc_unit.sv
// next pc computation
`timescale 1ns/1ps

module next_pc_unit (
	input  logic [fetch_pkg::addr_width-1:0] cur_pc,
	input  logic [fetch_pkg::data_width-1:0] cur_inst,
	input  logic                             cur_fault,
	output logic [fetch_pkg::addr_width-1:0] next_pc
);
	import fetch_pkg::*;
	import rv_pkg::*;

	logic [opcode_width-1:0] opcode;
	logic [jimm_width-1:0]   jimm;
	logic [addr_width-1:0]   jimm_ext;
	logic                    is_jal;

	assign opcode = cur_inst[opcode_width-1:0];

	// faulted words carry no valid encoding
	assign is_jal = !cur_fault && (opcode == opcode_jal);

	// J-type immediate, scrambled in the encoding
	assign jimm = {
		cur_inst[31],
		cur_inst[19:12],
		cur_inst[20],
		cur_inst[30:21],
		1'b0
	};

	// sign extend to the address width
	assign jimm_ext = {{(addr_width - jimm_width){jimm[jimm_width-1]}}, jimm};

	always_comb begin
		if (is_jal) begin
			next_pc = cur_pc + jimm_ext;
		end else begin
			next_pc = cur_pc + addr_width'(pc_step);
		end
	end

endmodule

//--- fetch_top.sv
// fetch stage top
`timescale 1ns/1ps

module fetch_top (
	input  logic                                   clk,
	input  logic                                   rst,

	input  logic                                   load_en,
	input  logic [fetch_pkg::mem_index_width-1:0]  load_index,
	input  logic [fetch_pkg::data_width-1:0]       load_data,

	output logic [fetch_pkg::addr_width-1:0]       out_pc,
	output logic [fetch_pkg::data_width-1:0]       out_inst,
	output logic                                   out_fault,
	output logic                                   out_valid,
	input  logic                                   out_ready
);
	import fetch_pkg::*;

	// read address channel
	logic [addr_width-1:0] araddr;
	logic                  arvalid;
	logic                  arready;

	// read data channel
	logic [data_width-1:0] rdata;
	logic [1:0]            rresp;
	logic                  rvalid;
	logic                  rready;

	// next-pc loop
	logic [addr_width-1:0] cur_pc;
	logic [data_width-1:0] cur_inst;
	logic                  cur_fault;
	logic [addr_width-1:0] next_pc;

	ifu ifu0 (
		.clk       (clk),
		.rst       (rst),
		.araddr    (araddr),
		.arvalid   (arvalid),
		.arready   (arready),
		.rdata     (rdata),
		.rresp     (rresp),
		.rvalid    (rvalid),
		.rready    (rready),
		.out_pc    (out_pc),
		.out_inst  (out_inst),
		.out_fault (out_fault),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.cur_pc    (cur_pc),
		.cur_inst  (cur_inst),
		.cur_fault (cur_fault),
		.next_pc   (next_pc)
	);

	isram isram0 (
		.clk        (clk),
		.rst        (rst),
		.araddr     (araddr),
		.arvalid    (arvalid),
		.arready    (arready),
		.rdata      (rdata),
		.rresp      (rresp),
		.rvalid     (rvalid),
		.rready     (rready),
		.load_en    (load_en),
		.load_index (load_index),
		.load_data  (load_data)
	);

	next_pc_unit npc0 (
		.cur_pc    (cur_pc),
		.cur_inst  (cur_inst),
		.cur_fault (cur_fault),
		.next_pc   (next_pc)
	);

endmodule

//--- fetch_checker.sv
// fetch output checker
`timescale 1ns/1ps

module fetch_checker (
	input  logic                             clk,
	input  logic                             rst,
	input  logic [fetch_pkg::addr_width-1:0] out_pc,
	input  logic [fetch_pkg::data_width-1:0] out_inst,
	input  logic                             out_fault,
	input  logic                             out_valid,
	input  logic                             out_ready,
	output int                               cur_test,
	output int                               tests,
	output int                               checks,
	output int                               errors,
	output logic                             done
);
	import fetch_pkg::*;

	// expected stream, in transfer order
	int                    exp_test[$];
	logic [addr_width-1:0] exp_pc[$];
	logic [data_width-1:0] exp_inst[$];
	logic                  exp_fault[$];

	// output seen while stalled on the previous edge
	logic                  held;
	logic [addr_width-1:0] held_pc;
	logic [data_width-1:0] held_inst;
	logic                  held_fault;
	logic                  prev_rst;
	int                    test_checks;
	int                    test_errors;

	initial begin
		done = 1'b0;
	end

	task automatic add_expected(input int test, input logic [addr_width-1:0] pc,
		input logic [data_width-1:0] inst, input logic fault);
		if (exp_test.size() == 0) begin
			cur_test = test;
		end
		exp_test.push_back(test);
		exp_pc.push_back(pc);
		exp_inst.push_back(inst);
		exp_fault.push_back(fault);
	endtask

	task automatic report_error(input string msg);
		$display("CHECK FAILED at %0t: %s", $time, msg);
		errors++;
		test_errors++;
	endtask

	always @(posedge clk) begin
		int t;
		if (rst) begin
			held     <= 1'b0;
			prev_rst <= 1'b1;
		end else begin
			if (prev_rst && out_valid) begin
				report_error("out_valid high in the first cycle after reset");
			end
			// a stalled word must stay put until taken
			if (held && (!out_valid || out_pc !== held_pc || out_inst !== held_inst
				|| out_fault !== held_fault)) begin
				report_error($sformatf("output changed during a stall at pc %h", held_pc));
			end
			if (out_valid && out_ready && exp_test.size() != 0) begin
				t = exp_test[0];
				checks++;
				test_checks++;
				if (out_pc !== exp_pc[0] || out_inst !== exp_inst[0]
					|| out_fault !== exp_fault[0]) begin
					report_error($sformatf(
						"test %0d got pc %h inst %h fault %b, expected pc %h inst %h fault %b",
						t, out_pc, out_inst, out_fault, exp_pc[0], exp_inst[0], exp_fault[0]));
				end
				exp_test.delete(0);
				exp_pc.delete(0);
				exp_inst.delete(0);
				exp_fault.delete(0);
				// last transfer of this test
				if (exp_test.size() == 0 || exp_test[0] != t) begin
					$display("test %0d finished: %0d transfers, %0d errors",
						t, test_checks, test_errors);
					tests++;
					test_checks = 0;
					test_errors = 0;
				end
				if (exp_test.size() == 0) begin
					done <= 1'b1;
				end else begin
					cur_test <= exp_test[0];
				end
			end
			held       <= out_valid && !out_ready;
			held_pc    <= out_pc;
			held_inst  <= out_inst;
			held_fault <= out_fault;
			prev_rst   <= 1'b0;
		end
	end

endmodule

//--- tb_fetch.sv
// fetch stage testbench
`timescale 1ns/1ps

module tb_fetch;
	import fetch_pkg::*;

	localparam int          reset_cycles     = 8;
	localparam int          cycles_per_fetch = 6;
	localparam int          random_from_test = 4;
	localparam logic [31:0] lfsr_seed        = 32'd71015;
	localparam logic [31:0] lfsr_mask        = 32'h8020_0003;

	logic                       clk = 1'b0;
	logic                       rst;
	logic                       load_en;
	logic [mem_index_width-1:0] load_index;
	logic [data_width-1:0]      load_data;
	logic [addr_width-1:0]      out_pc;
	logic [data_width-1:0]      out_inst;
	logic                       out_fault;
	logic                       out_valid;
	logic                       out_ready = 1'b1;
	logic [31:0]                lfsr = lfsr_seed;
	int                         cur_test;
	int                         tests;
	int                         checks;
	int                         errors;
	logic                       done;
	int                         limit_cycles = 0;

	// preload words from the stimulus file
	logic [mem_index_width-1:0] load_idx_q[$];
	logic [data_width-1:0]      load_word_q[$];

	always #5 clk = ~clk;

	fetch_top dut0 (
		.clk        (clk),
		.rst        (rst),
		.load_en    (load_en),
		.load_index (load_index),
		.load_data  (load_data),
		.out_pc     (out_pc),
		.out_inst   (out_inst),
		.out_fault  (out_fault),
		.out_valid  (out_valid),
		.out_ready  (out_ready)
	);

	fetch_checker chk0 (
		.clk       (clk),
		.rst       (rst),
		.out_pc    (out_pc),
		.out_inst  (out_inst),
		.out_fault (out_fault),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.cur_test  (cur_test),
		.tests     (tests),
		.checks    (checks),
		.errors    (errors),
		.done      (done)
	);

	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		if (s[0]) begin
			return (s >> 1) ^ lfsr_mask;
		end
		return s >> 1;
	endfunction

	// L lines go to the load queues, E lines to the checker
	task automatic read_stimulus(output int n_exp);
		int          fd;
		int          n;
		int          t;
		string       line;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		n_exp = 0;
		fd = $fopen("fetch_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open fetch_stimulus.txt");
			return;
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			if (n == 0 || line.len() < 2 || line.getc(0) == "#") begin
				continue;
			end
			if ($sscanf(line, "L %h %h", a, b) == 2) begin
				load_idx_q.push_back(a[mem_index_width-1:0]);
				load_word_q.push_back(b);
			end else if ($sscanf(line, "E %d %h %h %h", t, a, b, c) == 4) begin
				chk0.add_expected(t, a, b, c[0]);
				n_exp++;
			end
		end
		$fclose(fd);
	endtask

	// random back-pressure only in the later tests
	always @(posedge clk) begin
		if (rst || cur_test < random_from_test) begin
			out_ready <= 1'b1;
		end else begin
			out_ready <= lfsr[0];
			lfsr      <= lfsr_step(lfsr);
		end
	end

	initial begin
		int n_exp;
		rst        = 1'b1;
		load_en    = 1'b0;
		load_index = '0;
		load_data  = '0;
		read_stimulus(n_exp);
		if (n_exp == 0 || load_idx_q.size() > reset_cycles) begin
			$display("stimulus file is missing, has no expected lines or too many load words");
			$display("Simulation failed");
			$finish;
		end else begin
			limit_cycles = n_exp * cycles_per_fetch * 4 + reset_cycles + 2;
			// memory is filled while the fetch unit sits in reset
			for (int i = 0; i < reset_cycles; i++) begin
				@(posedge clk);
				if (i < load_idx_q.size()) begin
					load_en    <= 1'b1;
					load_index <= load_idx_q[i];
					load_data  <= load_word_q[i];
				end else begin
					load_en <= 1'b0;
				end
			end
			@(posedge clk);
			load_en <= 1'b0;
			rst     <= 1'b0;
			wait (done);
			$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
			if (errors == 0) begin
				$display("Simulation completed successfully");
			end else begin
				$display("Simulation failed");
			end
			$finish;
		end
	end

	// watchdog
	initial begin
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("timeout after %0d cycles with %0d of the expected transfers seen",
			limit_cycles, checks);
		$display("Simulation failed");
		$finish;
	end

endmodule

//--- filelist.f
fetch_pkg.sv
rv_pkg.sv
ifu.sv
isram.sv
next_pc_unit.sv
fetch_top.sv
fetch_checker.sv
tb_fetch.sv

//--- fetch_stimulus.txt
# each L line loads one word given as word index then data in hex
# each E line is one expected transfer with test number, pc, instruction and fault
L 00 00000013
L 01 00100093
L 02 00200113
L 03 00c0006f
L 04 00400213
L 05 0000106f
L 06 00300193
L 07 ff5ff06f
E 1 80000000 00000013 0
E 2 80000004 00100093 0
E 2 80000008 00200113 0
E 3 8000000c 00c0006f 0
E 3 80000018 00300193 0
E 3 8000001c ff5ff06f 0
E 4 80000010 00400213 0
E 4 80000014 0000106f 0
E 5 80001014 00000000 1
E 5 80001018 00000000 1
